//--- gpu_mem_pkg.sv
`default_nettype none

package gpu_mem_pkg;

	localparam int NUM_LANES   = 8;
	localparam int WORD_W      = 32;
	localparam int LINE_ADDR_W = 27;
	localparam int WOFS_W      = 3;
	localparam int LAT_W       = 5;
	localparam int CACHE_LINES = 32;
	localparam int CACHE_IDX_W = 5;
	localparam int LAT_ENTRIES = 256;
	localparam int LAT_IDX_W   = 8;

	typedef logic [NUM_LANES-1:0][WORD_W-1:0] lane_words_t; // Lane 0 in the low word

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage request and result
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic                   mem_read;
		logic                   mem_write;
		logic                   shared_global_bar; // 1 = shared, 0 = global
		logic [2:0]             warp_id;
		logic [1:0]             scb_id;
		logic [NUM_LANES-1:0]   pam;
		logic [4:0]             reg_addr;
		logic [LINE_ADDR_W-1:0] addr_sel;
		logic [31:0]            instr;
		lane_words_t            eff_addr;
		lane_words_t            write_data;
	} mem_req_t;

	typedef struct packed {
		logic                          addr_valid;
		logic                          mem_read;
		logic                          mem_write;
		logic                          hit_missbar;
		logic                          miss_wait;
		logic [LINE_ADDR_W-1:0]        mem_addr;
		lane_words_t                   write_data;
		logic [2:0]                    warp_id;
		logic [1:0]                    scb_id;
		logic [NUM_LANES-1:0]          mem_write_mask;
		logic [NUM_LANES*WOFS_W-1:0]   word_offset;
		logic [4:0]                    reg_addr;
		logic [NUM_LANES-1:0]          thread_mask;
		logic [LAT_W-1:0]              miss_latency;
		logic [31:0]                   instr;
	} mem_res_t;

	// Latency table write port
	typedef struct packed {
		logic                 wen;
		logic [LAT_IDX_W-1:0] addr;
		logic [LAT_W-1:0]     din;
	} lat_prog_t;

	typedef struct packed {
		logic                   valid;
		logic [LINE_ADDR_W-1:0] line_addr;
	} fill_fb_t;

endpackage

`default_nettype wire

//--- mem_coalescer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_coalescer
(
	input  wire gpu_mem_pkg::lane_words_t                   eff_addr_i,
	input  wire gpu_mem_pkg::lane_words_t                   write_data_i,
	input  wire [gpu_mem_pkg::NUM_LANES-1:0]                pam_i,
	input  wire [gpu_mem_pkg::LINE_ADDR_W-1:0]              addr_sel_i,
	output logic [gpu_mem_pkg::NUM_LANES-1:0]               thread_mask_o,
	output logic [gpu_mem_pkg::NUM_LANES-1:0]               write_mask_o,
	output gpu_mem_pkg::lane_words_t                        write_data_o
);

	import gpu_mem_pkg::*;

	logic [WOFS_W-1:0] lane_ofs [NUM_LANES];
	logic [WOFS_W-1:0] grant [NUM_LANES];     // Winning lane per word slot

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Thread mask
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			lane_ofs[i] = eff_addr_i[i][WOFS_W+1:2]; // Skip byte bits
			thread_mask_o[i] = pam_i[i] &&
				(eff_addr_i[i][WORD_W-1:WORD_W-LINE_ADDR_W] == addr_sel_i);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Store word coalescing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Scan from the top lane down so the lowest matching lane wins
	always_comb
	begin
		for (int j = 0; j < NUM_LANES; j++)
		begin
			write_mask_o[j] = 1'b0;
			grant[j] = '0;
			for (int i = NUM_LANES-1; i >= 0; i--)
			begin
				if (thread_mask_o[i] && (lane_ofs[i] == WOFS_W'(j)))
				begin
					write_mask_o[j] = 1'b1;
					grant[j] = WOFS_W'(i);
				end
			end
		end
	end

	always_comb
	begin
		for (int j = 0; j < NUM_LANES; j++)
		begin
			write_data_o[j] = write_data_i[grant[j]]; // Lane 0 data when unwritten
		end
	end

endmodule

`default_nettype wire

//--- miss_latency_timer.sv
`timescale 1ns/1ps
`default_nettype none

module miss_latency_timer
(
	input  wire                            clk,
	input  wire                            resetb,
	input  wire                            load_i,
	input  wire [gpu_mem_pkg::LAT_W-1:0]   count_i,
	output logic                           done_o
);

	import gpu_mem_pkg::*;

	logic [LAT_W-1:0] count_q;

	always_ff @(posedge clk)
	begin
		if (!resetb)
			count_q <= '0;
		else if (load_i)
			count_q <= count_i;
		else if (count_q != '0)
			count_q <= count_q - 1'b1;
	end

	assign done_o = (count_q == '0); // Holds at zero

	// The miss FSM only reloads once the previous latency has run out
	a_no_load_while_running: assert property (
		@(posedge clk) disable iff (!resetb)
		load_i |-> done_o
	);

endmodule

`default_nettype wire

//--- miss_track_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module miss_track_fsm
(
	input  wire                                  clk,
	input  wire                                  resetb,
	input  wire                                  start_i,
	input  wire [gpu_mem_pkg::LINE_ADDR_W-1:0]   line_addr_i,
	input  wire [gpu_mem_pkg::LAT_W-1:0]         latency_i,
	input  wire gpu_mem_pkg::fill_fb_t           fill_i,
	input  wire                                  timer_done_i,
	output logic                                 timer_load_o,
	output logic [gpu_mem_pkg::LAT_W-1:0]        timer_count_o,
	output logic                                 install_o,
	output logic [gpu_mem_pkg::LINE_ADDR_W-1:0]  install_addr_o,
	output logic                                 miss_wait_o
);

	import gpu_mem_pkg::*;

	typedef enum logic [1:0] {IDLE, WAIT_LAT, WAIT_FILL} state_t;

	state_t                 state_q, state_d;
	logic                   fill_seen_q, fill_seen_d; // Early fill remembered
	logic [LINE_ADDR_W-1:0] line_q;
	logic                   fill_match;
	logic                   fill_match_start;

	assign fill_match       = fill_i.valid && (fill_i.line_addr == line_q);
	assign fill_match_start = fill_i.valid && (fill_i.line_addr == line_addr_i);

	always_comb
	begin
		state_d      = state_q;
		fill_seen_d  = fill_seen_q;
		timer_load_o = 1'b0;
		install_o    = 1'b0;
		case (state_q)
			IDLE:
			begin
				if (start_i)
				begin
					timer_load_o = 1'b1;
					fill_seen_d  = fill_match_start;
					state_d      = WAIT_LAT;
				end
			end
			WAIT_LAT:
			begin
				if (fill_match)
					fill_seen_d = 1'b1;
				if (timer_done_i)
				begin
					if (fill_seen_q || fill_match)
					begin
						install_o   = 1'b1;
						fill_seen_d = 1'b0;
						state_d     = IDLE;
					end
					else
						state_d = WAIT_FILL;
				end
			end
			WAIT_FILL:
			begin
				if (fill_match)
				begin
					install_o   = 1'b1;
					fill_seen_d = 1'b0;
					state_d     = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			state_q     <= IDLE;
			fill_seen_q <= 1'b0;
		end
		else
		begin
			state_q     <= state_d;
			fill_seen_q <= fill_seen_d;
		end
	end

	// Tracked line, captured only when a miss is accepted
	always_ff @(posedge clk)
	begin
		if (state_q == IDLE && start_i)
			line_q <= line_addr_i;
	end

	assign timer_count_o  = latency_i;
	assign install_addr_o = line_q;
	assign miss_wait_o    = (state_q != IDLE) || start_i; // High in the miss cycle itself

	// Install never comes before the latency has run out
	a_install_when_busy: assert property (
		@(posedge clk) disable iff (!resetb)
		install_o |-> (state_q != IDLE) && timer_done_i
	);

endmodule

`default_nettype wire

//--- cache_latency_emulator.sv
`timescale 1ns/1ps
`default_nettype none

module cache_latency_emulator
(
	input  wire                                  clk,
	input  wire                                  resetb,
	input  wire                                  lookup_i,
	input  wire [gpu_mem_pkg::LINE_ADDR_W-1:0]   addr_i,
	input  wire gpu_mem_pkg::fill_fb_t           fill_i,
	input  wire gpu_mem_pkg::lat_prog_t          lat_prog_i,
	input  wire [gpu_mem_pkg::LAT_IDX_W-1:0]     lat_rd_addr_i,
	output logic [gpu_mem_pkg::LAT_W-1:0]        lat_rd_data_o,
	output logic                                 hit_missbar_o,
	output logic [gpu_mem_pkg::LAT_W-1:0]        latency_o,
	output logic                                 miss_wait_o
);

	import gpu_mem_pkg::*;

	logic [LINE_ADDR_W-1:CACHE_IDX_W] tag_mem [CACHE_LINES];
	logic [CACHE_LINES-1:0]           valid_q;
	logic [LAT_W-1:0]                 lat_mem [LAT_ENTRIES];

	logic                   lookup_q;
	logic [LINE_ADDR_W-1:0] addr_q;
	logic [CACHE_IDX_W-1:0] idx;
	logic                   miss_start;
	logic                   timer_load;
	logic [LAT_W-1:0]       timer_count;
	logic                   timer_done;
	logic                   install;
	logic [LINE_ADDR_W-1:0] install_addr;

	always_ff @(posedge clk)
	begin
		if (!resetb)
			lookup_q <= 1'b0;
		else
			lookup_q <= lookup_i;
	end

	always_ff @(posedge clk)
	begin
		addr_q <= addr_i;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tag store and latency table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (!resetb)
			valid_q <= '0;
		else if (install)
			valid_q[install_addr[CACHE_IDX_W-1:0]] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (install)
			tag_mem[install_addr[CACHE_IDX_W-1:0]] <= install_addr[LINE_ADDR_W-1:CACHE_IDX_W];
		if (lat_prog_i.wen)
			lat_mem[lat_prog_i.addr] <= lat_prog_i.din;
	end

	assign lat_rd_data_o = lat_mem[lat_rd_addr_i];

	assign idx           = addr_q[CACHE_IDX_W-1:0];
	assign hit_missbar_o = valid_q[idx] && (tag_mem[idx] == addr_q[LINE_ADDR_W-1:CACHE_IDX_W]);
	assign latency_o     = lat_mem[addr_q[LAT_IDX_W-1:0]];
	assign miss_start    = lookup_q && !hit_missbar_o; // FSM drops it when busy

	miss_track_fsm i_miss_fsm
	(
		.clk            (clk),
		.resetb         (resetb),
		.start_i        (miss_start),
		.line_addr_i    (addr_q),
		.latency_i      (latency_o),
		.fill_i         (fill_i),
		.timer_done_i   (timer_done),
		.timer_load_o   (timer_load),
		.timer_count_o  (timer_count),
		.install_o      (install),
		.install_addr_o (install_addr),
		.miss_wait_o    (miss_wait_o)
	);

	miss_latency_timer i_miss_timer
	(
		.clk     (clk),
		.resetb  (resetb),
		.load_i  (timer_load),
		.count_i (timer_count),
		.done_o  (timer_done)
	);

endmodule

`default_nettype wire

//--- mem_stage2.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage2
(
	input  wire                               clk,
	input  wire                               resetb,
	input  wire gpu_mem_pkg::mem_req_t        req_i,
	input  wire gpu_mem_pkg::fill_fb_t        fill_fb_i,
	input  wire gpu_mem_pkg::lat_prog_t       lat_prog_i,
	input  wire [gpu_mem_pkg::LAT_IDX_W-1:0]  lat_rd_addr_i,
	output gpu_mem_pkg::mem_res_t             res_o,
	output logic [gpu_mem_pkg::LAT_W-1:0]     lat_rd_data_o
);

	import gpu_mem_pkg::*;

	mem_req_t               req_q;
	logic                   lookup;
	logic                   addr_valid_q;
	logic [NUM_LANES-1:0]   thread_mask;
	logic [NUM_LANES-1:0]   write_mask;
	lane_words_t            coal_data;
	logic                   hit_missbar;
	logic [LAT_W-1:0]       miss_latency;
	logic                   miss_wait;
	logic [NUM_LANES*WOFS_W-1:0] word_offset;
	logic                   pass_access;

	// Global accesses only go to the cache
	assign lookup = !req_i.shared_global_bar && (req_i.mem_read || req_i.mem_write);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Input and output registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			req_q.mem_read  <= 1'b0;
			req_q.mem_write <= 1'b0;
			addr_valid_q    <= 1'b0;
		end
		else
		begin
			req_q        <= req_i;
			addr_valid_q <= lookup;
		end
	end

	mem_coalescer i_coalescer
	(
		.eff_addr_i    (req_q.eff_addr),
		.write_data_i  (req_q.write_data),
		.pam_i         (req_q.pam),
		.addr_sel_i    (req_q.addr_sel),
		.thread_mask_o (thread_mask),
		.write_mask_o  (write_mask),
		.write_data_o  (coal_data)
	);

	cache_latency_emulator i_cle
	(
		.clk           (clk),
		.resetb        (resetb),
		.lookup_i      (lookup),
		.addr_i        (req_i.addr_sel),
		.fill_i        (fill_fb_i),
		.lat_prog_i    (lat_prog_i),
		.lat_rd_addr_i (lat_rd_addr_i),
		.lat_rd_data_o (lat_rd_data_o),
		.hit_missbar_o (hit_missbar),
		.latency_o     (miss_latency),
		.miss_wait_o   (miss_wait)
	);

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			word_offset[i*WOFS_W +: WOFS_W] = req_q.eff_addr[i][WOFS_W+1:2];
		end
	end

	assign pass_access = hit_missbar || req_q.shared_global_bar; // Shared never misses

	always_comb
	begin
		res_o.addr_valid     = addr_valid_q;
		res_o.mem_read       = req_q.mem_read && pass_access;
		res_o.mem_write      = req_q.mem_write && pass_access;
		res_o.hit_missbar    = hit_missbar;
		res_o.miss_wait      = miss_wait;
		res_o.mem_addr       = req_q.addr_sel;
		res_o.write_data     = coal_data;
		res_o.warp_id        = req_q.warp_id;
		res_o.scb_id         = req_q.scb_id;
		res_o.mem_write_mask = write_mask;
		res_o.word_offset    = word_offset;
		res_o.reg_addr       = req_q.reg_addr;
		res_o.thread_mask    = thread_mask;
		res_o.miss_latency   = miss_latency;
		res_o.instr          = req_q.instr;
	end

	// Active threads always claim a word slot, and only they do
	a_write_mask_covers_threads: assert property (
		@(posedge clk) disable iff (!resetb)
		(req_q.mem_read || req_q.mem_write) |-> ((|thread_mask) == (|write_mask))
	);

endmodule

`default_nettype wire

//--- gpu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_mem_top
(
	input  wire                               clk,
	input  wire                               resetb,
	input  wire gpu_mem_pkg::mem_req_t        req_i,
	input  wire gpu_mem_pkg::fill_fb_t        fill_fb_i,
	input  wire gpu_mem_pkg::lat_prog_t       lat_prog_i,
	input  wire [gpu_mem_pkg::LAT_IDX_W-1:0]  lat_rd_addr_i,
	output gpu_mem_pkg::mem_res_t             res_o,
	output logic [gpu_mem_pkg::LAT_W-1:0]     lat_rd_data_o
);

	mem_stage2 i_mem_stage2
	(
		.clk           (clk),
		.resetb        (resetb),
		.req_i         (req_i),
		.fill_fb_i     (fill_fb_i),
		.lat_prog_i    (lat_prog_i),
		.lat_rd_addr_i (lat_rd_addr_i),
		.res_o         (res_o),
		.lat_rd_data_o (lat_rd_data_o)
	);

endmodule

`default_nettype wire

//--- tb_gpu_mem_tasks.svh
`ifndef TB_GPU_MEM_TASKS_SVH
`define TB_GPU_MEM_TASKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// First active lane to claim a word slot keeps it
function automatic void predict_coalesced(input mem_req_t r,
	output logic [NUM_LANES-1:0] tmask, output logic [NUM_LANES-1:0] wmask,
	output lane_words_t wdata, output logic [NUM_LANES*WOFS_W-1:0] wofs);
	logic [WOFS_W-1:0] slot;
	tmask = '0;
	wmask = '0;
	for (int j = 0; j < NUM_LANES; j++)
		wdata[j] = r.write_data[0];
	for (int i = 0; i < NUM_LANES; i++)
	begin
		slot = r.eff_addr[i][4:2];
		wofs[i*WOFS_W +: WOFS_W] = slot;
		tmask[i] = r.pam[i] && (r.eff_addr[i][31:5] == r.addr_sel);
		if (tmask[i] && !wmask[slot])
		begin
			wmask[slot] = 1'b1;
			wdata[slot] = r.write_data[i];
		end
	end
endfunction

function automatic logic tag_model_hit(input logic [LINE_ADDR_W-1:0] line);
	return tag_valid_model[line[CACHE_IDX_W-1:0]] && (tag_model[line[CACHE_IDX_W-1:0]] == line);
endfunction

function automatic void record_install(input logic [LINE_ADDR_W-1:0] line);
	tag_valid_model[line[CACHE_IDX_W-1:0]] = 1'b1;
	tag_model[line[CACHE_IDX_W-1:0]]       = line;
endfunction

function automatic logic [LINE_ADDR_W-1:0] pick_uncached_line();
	logic [LINE_ADDR_W-1:0] line;
	line = LINE_ADDR_W'($urandom);
	for (int k = 0; k < CACHE_LINES && tag_model_hit(line); k++)
		line[CACHE_IDX_W-1:0] = line[CACHE_IDX_W-1:0] + 1'b1; // Step to a free index
	return line;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stimulus helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic write_latency_entry(input logic [LAT_IDX_W-1:0] idx, input logic [LAT_W-1:0] val);
	lat_prog.wen  = 1'b1;
	lat_prog.addr = idx;
	lat_prog.din  = val;
	@(negedge clk);
	lat_prog       = '0;
	lat_model[idx] = val;
endtask

// Read of a whole line, checked one cycle later
task automatic issue_global_read(input logic [LINE_ADDR_W-1:0] line, input logic exp_hit);
	mem_req_t r;
	r          = '0;
	r.mem_read = 1'b1;
	r.pam      = '1;
	r.addr_sel = line;
	for (int i = 0; i < NUM_LANES; i++)
		r.eff_addr[i] = {line, WOFS_W'(i), 2'b00};
	req = r;
	@(negedge clk);
	compare_value("addr_valid", res.addr_valid, 1'b1);
	compare_value("hit_missbar", res.hit_missbar, exp_hit);
	compare_value("mem_read", res.mem_read, exp_hit);
	compare_value("mem_addr", res.mem_addr, line);
	compare_value("miss_latency", res.miss_latency, lat_model[line[LAT_IDX_W-1:0]]);
	if (!exp_hit)
		compare_value("miss_wait", res.miss_wait, 1'b1);
	req = '0;
endtask

task automatic send_fill(input logic [LINE_ADDR_W-1:0] line);
	fill_fb.valid     = 1'b1;
	fill_fb.line_addr = line;
	@(negedge clk);
	fill_fb = '0;
endtask

task automatic expect_miss_wait_high(input int cycles);
	for (int k = 0; k < cycles; k++)
	begin
		@(negedge clk);
		compare_value("miss_wait", res.miss_wait, 1'b1);
	end
endtask

// Counts from the cycle the miss was reported
task automatic wait_for_miss_clear(input int start_cnt, output int high_cycles);
	high_cycles = start_cnt;
	while (res.miss_wait === 1'b1 && high_cycles < MISS_TIMEOUT)
	begin
		@(negedge clk);
		high_cycles++;
	end
	if (res.miss_wait !== 1'b0)
		abort_run("Timed out waiting for miss_wait to fall");
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_reset_state();
	compare_value("addr_valid", res.addr_valid, 1'b0);
	compare_value("mem_read", res.mem_read, 1'b0);
	compare_value("mem_write", res.mem_write, 1'b0);
	compare_value("miss_wait", res.miss_wait, 1'b0);
endtask

task automatic coalesce_shared_stores(input int count);
	mem_req_t                    r;
	logic [NUM_LANES-1:0]        tmask;
	logic [NUM_LANES-1:0]        wmask;
	lane_words_t                 wdata;
	logic [NUM_LANES*WOFS_W-1:0] wofs;
	logic [LINE_ADDR_W-1:0]      line;
	for (int k = 0; k < count; k++)
	begin
		r                   = '0;
		r.mem_write         = 1'b1;
		r.shared_global_bar = 1'b1;
		r.warp_id           = 3'($urandom);
		r.scb_id            = 2'($urandom);
		r.reg_addr          = 5'($urandom);
		r.instr             = $urandom;
		r.pam               = 8'($urandom);
		r.addr_sel          = LINE_ADDR_W'($urandom);
		for (int i = 0; i < NUM_LANES; i++)
		begin
			line = r.addr_sel;
			if ($urandom_range(3) == 0)
				line = line ^ LINE_ADDR_W'($urandom_range(15, 1)); // Lane off the line
			r.eff_addr[i]   = {line, WOFS_W'($urandom_range(7)), 2'($urandom)};
			r.write_data[i] = $urandom;
		end
		predict_coalesced(r, tmask, wmask, wdata, wofs);
		req = r;
		@(negedge clk);
		compare_value("thread_mask", res.thread_mask, tmask);
		compare_value("mem_write_mask", res.mem_write_mask, wmask);
		compare_value("write_data", res.write_data, wdata);
		compare_value("word_offset", res.word_offset, wofs);
		compare_value("mem_write", res.mem_write, 1'b1);
		compare_value("mem_read", res.mem_read, 1'b0);
		compare_value("addr_valid", res.addr_valid, 1'b0);
		compare_value("mem_addr", res.mem_addr, r.addr_sel);
		compare_value("warp_id", res.warp_id, r.warp_id);
		compare_value("scb_id", res.scb_id, r.scb_id);
		compare_value("reg_addr", res.reg_addr, r.reg_addr);
		compare_value("instr", res.instr, r.instr);
	end
	req = '0;
endtask

task automatic program_and_read_latency(input int count);
	logic [LAT_IDX_W-1:0] idx;
	logic [LAT_IDX_W-1:0] written [$];
	for (int k = 0; k < count; k++)
	begin
		idx = LAT_IDX_W'($urandom);
		write_latency_entry(idx, LAT_W'($urandom));
		written.push_back(idx);
	end
	foreach (written[k])
	begin
		lat_rd_addr = written[k];
		@(negedge clk);
		compare_value("lat_rd_data", lat_rd_data, lat_model[written[k]]);
	end
endtask

task automatic miss_with_early_fill();
	logic [LINE_ADDR_W-1:0] line;
	int                     high;
	line = pick_uncached_line();
	write_latency_entry(line[LAT_IDX_W-1:0], LAT_W'(6));
	issue_global_read(line, tag_model_hit(line));
	expect_miss_wait_high(1);
	send_fill(line); // Timer still running
	wait_for_miss_clear(2, high);
	check_wait_length(high, 6);
	record_install(line);
	issue_global_read(line, tag_model_hit(line));
endtask

task automatic miss_with_late_fill();
	logic [LINE_ADDR_W-1:0] line;
	int                     high;
	line = pick_uncached_line();
	write_latency_entry(line[LAT_IDX_W-1:0], LAT_W'(2));
	issue_global_read(line, tag_model_hit(line));
	expect_miss_wait_high(6);
	send_fill(line);
	wait_for_miss_clear(7, high);
	record_install(line);
	issue_global_read(line, tag_model_hit(line));
endtask

task automatic ignore_foreign_fill();
	logic [LINE_ADDR_W-1:0] line;
	int                     high;
	line = pick_uncached_line();
	write_latency_entry(line[LAT_IDX_W-1:0], LAT_W'(1));
	issue_global_read(line, tag_model_hit(line));
	expect_miss_wait_high(3);
	send_fill(line ^ LINE_ADDR_W'('h40));
	expect_miss_wait_high(3);
	send_fill(line);
	wait_for_miss_clear(8, high);
	record_install(line);
	issue_global_read(line, tag_model_hit(line));
endtask

task automatic second_miss_not_tracked();
	logic [LINE_ADDR_W-1:0] line_a;
	logic [LINE_ADDR_W-1:0] line_b;
	int                     high;
	line_a = pick_uncached_line();
	line_b = pick_uncached_line();
	for (int k = 0; k < 4 && line_b == line_a; k++)
		line_b = pick_uncached_line();
	write_latency_entry(line_a[LAT_IDX_W-1:0], LAT_W'(3));
	write_latency_entry(line_b[LAT_IDX_W-1:0], LAT_W'(4));
	issue_global_read(line_a, tag_model_hit(line_a));
	issue_global_read(line_b, tag_model_hit(line_b)); // Arrives while A is tracked
	expect_miss_wait_high(2);
	send_fill(line_b);
	expect_miss_wait_high(3);
	send_fill(line_a);
	wait_for_miss_clear(8, high);
	record_install(line_a);
	issue_global_read(line_a, tag_model_hit(line_a));
	// B was never installed
	issue_global_read(line_b, tag_model_hit(line_b));
	send_fill(line_b);
	wait_for_miss_clear(1, high);
	record_install(line_b);
	issue_global_read(line_b, tag_model_hit(line_b));
endtask

`endif

//--- tb_gpu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpu_mem;

	import gpu_mem_pkg::*;

	localparam int SEED         = 41005;
	localparam int MISS_TIMEOUT = 100; // Cycles allowed for one miss to clear

	logic                 clk;
	logic                 resetb;
	mem_req_t             req;
	fill_fb_t             fill_fb;
	lat_prog_t            lat_prog;
	logic [LAT_IDX_W-1:0] lat_rd_addr;
	mem_res_t             res;
	logic [LAT_W-1:0]     lat_rd_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [LAT_W-1:0]       lat_model [LAT_ENTRIES];
	logic [LINE_ADDR_W-1:0] tag_model [CACHE_LINES]; // Whole line kept per index
	logic [CACHE_LINES-1:0] tag_valid_model;

	gpu_mem_top i_dut
	(
		.clk           (clk),
		.resetb        (resetb),
		.req_i         (req),
		.fill_fb_i     (fill_fb),
		.lat_prog_i    (lat_prog),
		.lat_rd_addr_i (lat_rd_addr),
		.res_o         (res),
		.lat_rd_data_o (lat_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_wait_length(input int high_cycles, input int latency);
		assert (high_cycles >= latency)
		else
			abort_run($sformatf("miss_wait was high for %0d cycles, less than the latency %0d",
				high_cycles, latency));
	endtask

	`include "tb_gpu_mem_tasks.svh"

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		void'($urandom(SEED));
		resetb          = 1'b0;
		req             = '0;
		fill_fb         = '0;
		lat_prog        = '0;
		lat_rd_addr     = '0;
		tag_valid_model = '0;
		repeat (8) @(negedge clk);
		resetb = 1'b1;

		check_reset_state();
		coalesce_shared_stores(24);
		program_and_read_latency(16);
		miss_with_early_fill();
		miss_with_late_fill();
		ignore_foreign_fill();
		second_miss_not_tracked();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
gpu_mem_pkg.sv
mem_coalescer.sv
miss_latency_timer.sv
miss_track_fsm.sv
cache_latency_emulator.sv
mem_stage2.sv
gpu_mem_top.sv
tb_gpu_mem.sv

//--- Bender.yml
package:
  name: gpu_mem_stage2

sources:
  - files:
      - gpu_mem_pkg.sv
      - mem_coalescer.sv
      - miss_latency_timer.sv
      - miss_track_fsm.sv
      - cache_latency_emulator.sv
      - mem_stage2.sv
      - gpu_mem_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_gpu_mem.sv
